//--- rtl/z8Pkg.sv
package z8Pkg;

    typedef logic [7:0] byteT;
    typedef logic [3:0] regIdxT;

    // Upper nibble of the flag byte, carry at bit 7
    typedef struct packed {
        logic c;
        logic z;
        logic s;
        logic v;
    } flagsT;

    typedef struct packed {
        byteT opcode;
        byteT second;
        byteT third;
    } instrT;

    typedef struct packed {
        logic   writeEn;
        regIdxT dst;
        byteT   value;
        flagsT  flags;
    } resultT;

    typedef enum logic [4:0] {
        // Two-operand group
        AluAdd, AluAdc, AluSub, AluSbc, AluOr,
        AluAnd, AluTcm, AluTm, AluCp, AluXor,
        // Single-operand group
        AluDec, AluRlc, AluInc, AluCom, AluRl,
        AluClr, AluRrc, AluSra, AluRr, AluSwap,
        // Load and flag ops
        AluLd, AluScf, AluRcf, AluCcf, AluNop
    } aluOpT;

    // Opcode low nibbles of the kept groups
    localparam logic [3:0] LowReg2 = 4'h2;
    localparam logic [3:0] LowImm2 = 4'h6;
    localparam logic [3:0] LowOp1 = 4'h0;
    localparam logic [3:0] LowLdImm = 4'hC;

    // Marks a working register in an operand byte
    localparam logic [3:0] WorkRegPrefix = 4'hE;

    // One-byte opcodes
    localparam byteT OpRcf = 8'hCF;
    localparam byteT OpScf = 8'hDF;
    localparam byteT OpCcf = 8'hEF;
    localparam byteT OpNop = 8'hFF;

    localparam int DefaultQueueDepth = 4;

endpackage

//--- rtl/z8Alu.sv
module z8Alu (
    input  z8Pkg::aluOpT op,
    input  z8Pkg::byteT  a,
    input  z8Pkg::byteT  b,
    input  z8Pkg::flagsT flagsIn,
    output z8Pkg::byteT  value,
    output z8Pkg::flagsT flagsOut
);
    logic       carryIn;
    logic [8:0] sum;
    logic [8:0] diff;
    logic       zsEn;

    assign carryIn = (op == z8Pkg::AluAdc || op == z8Pkg::AluSbc) ? flagsIn.c : 1'b0;

    // Bit 8 is the carry out, or the borrow for the difference
    assign sum = {1'b0, a} + {1'b0, b} + {8'b0, carryIn};
    assign diff = {1'b0, a} - {1'b0, b} - {8'b0, carryIn};

    assign zsEn = !(op inside {z8Pkg::AluClr, z8Pkg::AluLd, z8Pkg::AluNop,
                               z8Pkg::AluScf, z8Pkg::AluRcf, z8Pkg::AluCcf});

    always_comb begin
        value = a;
        flagsOut = flagsIn;
        case (op)
            z8Pkg::AluAdd, z8Pkg::AluAdc: begin
                value = sum[7:0];
                flagsOut.c = sum[8];
                flagsOut.v = (a[7] == b[7]) && (sum[7] != a[7]);
            end
            z8Pkg::AluSub, z8Pkg::AluSbc, z8Pkg::AluCp: begin
                value = diff[7:0];
                flagsOut.c = diff[8];
                flagsOut.v = (a[7] != b[7]) && (diff[7] != a[7]);
            end
            z8Pkg::AluOr: begin
                value = a | b;
                flagsOut.v = 1'b0;
            end
            z8Pkg::AluAnd, z8Pkg::AluTm: begin
                value = a & b;
                flagsOut.v = 1'b0;
            end
            z8Pkg::AluTcm: begin
                value = ~a & b;
                flagsOut.v = 1'b0;
            end
            z8Pkg::AluXor: begin
                value = a ^ b;
                flagsOut.v = 1'b0;
            end
            z8Pkg::AluInc: begin
                value = a + 8'd1;
                flagsOut.v = (a == 8'h7F);
            end
            z8Pkg::AluDec: begin
                value = a - 8'd1;
                flagsOut.v = (a == 8'h80);
            end
            z8Pkg::AluRlc: begin
                value = {a[6:0], flagsIn.c};
                flagsOut.c = a[7];
                flagsOut.v = value[7] ^ a[7];
            end
            z8Pkg::AluRl: begin
                value = {a[6:0], a[7]};
                flagsOut.c = a[7];
                flagsOut.v = value[7] ^ a[7];
            end
            z8Pkg::AluRrc: begin
                value = {flagsIn.c, a[7:1]};
                flagsOut.c = a[0];
                flagsOut.v = value[7] ^ a[7];
            end
            z8Pkg::AluRr: begin
                value = {a[0], a[7:1]};
                flagsOut.c = a[0];
                flagsOut.v = value[7] ^ a[7];
            end
            z8Pkg::AluSra: begin
                // Sign bit is kept, so V always clears
                value = {a[7], a[7:1]};
                flagsOut.c = a[0];
                flagsOut.v = value[7] ^ a[7];
            end
            z8Pkg::AluCom: begin
                value = ~a;
                flagsOut.v = 1'b0;
            end
            z8Pkg::AluSwap: begin
                value = {a[3:0], a[7:4]};
                flagsOut.v = 1'b0;
            end
            z8Pkg::AluClr: value = '0;
            z8Pkg::AluLd: value = b;
            z8Pkg::AluScf: flagsOut.c = 1'b1;
            z8Pkg::AluRcf: flagsOut.c = 1'b0;
            z8Pkg::AluCcf: flagsOut.c = ~flagsIn.c;
            default: value = a;
        endcase
        if (zsEn) begin
            flagsOut.z = (value == 8'h00);
            flagsOut.s = value[7];
        end
    end

endmodule

//--- rtl/instrAssembler.sv
module instrAssembler (
    input  logic         clk,
    input  logic         arstN,
    input  z8Pkg::byteT  inByte,
    input  logic         inValid,
    output logic         inReady,
    output z8Pkg::instrT asmInstr,
    output logic         asmValid,
    input  logic         asmReady
);
    logic [1:0] cnt;
    logic [1:0] curLen;
    logic       lastByte;
    logic       accept;

    // Instruction length from the opcode low nibble
    function automatic logic [1:0] instrLen(input z8Pkg::byteT opcode);
        logic [3:0] lo;
        lo = opcode[3:0];
        if (lo == 4'hF)
            instrLen = 2'd1;
        else if (lo inside {4'h4, 4'h5, 4'h6, 4'h7, 4'hD})
            instrLen = 2'd3;
        else
            instrLen = 2'd2;
    endfunction

    assign accept = inValid && inReady;
    assign curLen = (cnt == 2'd0) ? instrLen(inByte) : instrLen(asmInstr.opcode);
    assign lastByte = (cnt + 2'd1) == curLen;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cnt <= 2'd0;
            asmValid <= 1'b0;
            inReady <= 1'b0;
        end else if (asmValid) begin
            if (asmReady) begin
                asmValid <= 1'b0;
                inReady <= 1'b1;
            end
        end else begin
            inReady <= 1'b1;
            if (accept) begin
                if (lastByte) begin
                    cnt <= 2'd0;
                    asmValid <= 1'b1;
                    inReady <= 1'b0;
                end else begin
                    cnt <= cnt + 2'd1;
                end
            end
        end
    end

    // Unused trailing bytes read as zero
    always_ff @(posedge clk) begin
        if (accept) begin
            case (cnt)
                2'd0: begin
                    asmInstr.opcode <= inByte;
                    asmInstr.second <= '0;
                    asmInstr.third <= '0;
                end
                2'd1: asmInstr.second <= inByte;
                default: asmInstr.third <= inByte;
            endcase
        end
    end

endmodule

//--- rtl/instrQueue.sv
module instrQueue #(
    parameter int Depth = z8Pkg::DefaultQueueDepth
) (
    input  logic         clk,
    input  logic         arstN,
    input  z8Pkg::instrT wrData,
    input  logic         wrValid,
    output logic         wrReady,
    output z8Pkg::instrT rdData,
    output logic         rdValid,
    input  logic         rdReady
);
    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    z8Pkg::instrT    mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            doWrite;
    logic            doRead;

    // Wraps at Depth, which need not be a power of two
    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        nextPtr = (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign wrReady = (count != CntW'(Depth));
    assign rdValid = (count != '0);
    assign doWrite = wrValid && wrReady;
    assign doRead = rdValid && rdReady;
    assign rdData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doWrite)
            mem[wrPtr] <= wrData;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite)
                wrPtr <= nextPtr(wrPtr);
            if (doRead)
                rdPtr <= nextPtr(rdPtr);
            case ({doWrite, doRead})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rtl/execUnit.sv
module execUnit (
    input  logic          clk,
    input  logic          arstN,
    input  z8Pkg::instrT  instr,
    input  logic          instrValid,
    output logic          instrReady,
    output z8Pkg::resultT result,
    output logic          resultValid,
    input  logic          resultReady
);
    z8Pkg::byteT   regFile [16];
    z8Pkg::flagsT  flagsQ;
    z8Pkg::aluOpT  op;
    z8Pkg::regIdxT dst;
    z8Pkg::byteT   opA;
    z8Pkg::byteT   opB;
    z8Pkg::byteT   aluValue;
    z8Pkg::flagsT  aluFlags;
    logic [3:0]    hi;
    logic [3:0]    lo;
    logic          isWorkReg;
    logic          writeEn;
    logic          accept;

    function automatic z8Pkg::aluOpT alu2Op(input logic [3:0] code);
        case (code)
            4'h0: alu2Op = z8Pkg::AluAdd;
            4'h1: alu2Op = z8Pkg::AluAdc;
            4'h2: alu2Op = z8Pkg::AluSub;
            4'h3: alu2Op = z8Pkg::AluSbc;
            4'h4: alu2Op = z8Pkg::AluOr;
            4'h5: alu2Op = z8Pkg::AluAnd;
            4'h6: alu2Op = z8Pkg::AluTcm;
            4'h7: alu2Op = z8Pkg::AluTm;
            4'hA: alu2Op = z8Pkg::AluCp;
            4'hB: alu2Op = z8Pkg::AluXor;
            default: alu2Op = z8Pkg::AluNop;
        endcase
    endfunction

    // da, pop, push, decw and incw slots fall through to nop
    function automatic z8Pkg::aluOpT alu1Op(input logic [3:0] code);
        case (code)
            4'h0: alu1Op = z8Pkg::AluDec;
            4'h1: alu1Op = z8Pkg::AluRlc;
            4'h2: alu1Op = z8Pkg::AluInc;
            4'h6: alu1Op = z8Pkg::AluCom;
            4'h9: alu1Op = z8Pkg::AluRl;
            4'hB: alu1Op = z8Pkg::AluClr;
            4'hC: alu1Op = z8Pkg::AluRrc;
            4'hD: alu1Op = z8Pkg::AluSra;
            4'hE: alu1Op = z8Pkg::AluRr;
            4'hF: alu1Op = z8Pkg::AluSwap;
            default: alu1Op = z8Pkg::AluNop;
        endcase
    endfunction

    assign hi = instr.opcode[7:4];
    assign lo = instr.opcode[3:0];
    assign isWorkReg = (instr.second[7:4] == z8Pkg::WorkRegPrefix);

    always_comb begin
        op = z8Pkg::AluNop;
        dst = '0;
        opB = '0;
        if (lo == z8Pkg::LowReg2) begin
            op = alu2Op(hi);
            dst = instr.second[7:4];
            opB = regFile[instr.second[3:0]];
        end else if (lo == z8Pkg::LowImm2 && isWorkReg) begin
            op = alu2Op(hi);
            dst = instr.second[3:0];
            opB = instr.third;
        end else if (lo == z8Pkg::LowOp1 && isWorkReg) begin
            op = alu1Op(hi);
            dst = instr.second[3:0];
        end else if (lo == z8Pkg::LowLdImm) begin
            op = z8Pkg::AluLd;
            dst = hi;
            opB = instr.second;
        end else begin
            case (instr.opcode)
                z8Pkg::OpScf: op = z8Pkg::AluScf;
                z8Pkg::OpRcf: op = z8Pkg::AluRcf;
                z8Pkg::OpCcf: op = z8Pkg::AluCcf;
                z8Pkg::OpNop: op = z8Pkg::AluNop;
                default: op = z8Pkg::AluNop;
            endcase
        end
    end

    // Destination is also the first operand
    assign opA = regFile[dst];

    assign writeEn = !(op inside {z8Pkg::AluCp, z8Pkg::AluTm, z8Pkg::AluTcm,
                                  z8Pkg::AluScf, z8Pkg::AluRcf, z8Pkg::AluCcf,
                                  z8Pkg::AluNop});

    assign instrReady = !resultValid || resultReady;
    assign accept = instrValid && instrReady;

    z8Alu alu (
        .op(op),
        .a(opA),
        .b(opB),
        .flagsIn(flagsQ),
        .value(aluValue),
        .flagsOut(aluFlags)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 16; i++)
                regFile[i] <= '0;
            flagsQ <= '0;
            resultValid <= 1'b0;
        end else if (accept) begin
            if (writeEn)
                regFile[dst] <= aluValue;
            flagsQ <= aluFlags;
            resultValid <= 1'b1;
        end else if (resultReady) begin
            resultValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            result <= '{writeEn: writeEn, dst: dst, value: aluValue, flags: aluFlags};
    end

endmodule

//--- rtl/z8Core.sv
module z8Core #(
    parameter int QueueDepth = z8Pkg::DefaultQueueDepth
) (
    input  logic          clk,
    input  logic          arstN,
    input  z8Pkg::byteT   inByte,
    input  logic          inValid,
    output logic          inReady,
    output z8Pkg::resultT result,
    output logic          resultValid,
    input  logic          resultReady
);
    z8Pkg::instrT asmInstr;
    logic         asmValid;
    logic         asmReady;
    z8Pkg::instrT qInstr;
    logic         qValid;
    logic         qReady;

    instrAssembler assembler (
        .clk(clk),
        .arstN(arstN),
        .inByte(inByte),
        .inValid(inValid),
        .inReady(inReady),
        .asmInstr(asmInstr),
        .asmValid(asmValid),
        .asmReady(asmReady)
    );

    instrQueue #(
        .Depth(QueueDepth)
    ) queue (
        .clk(clk),
        .arstN(arstN),
        .wrData(asmInstr),
        .wrValid(asmValid),
        .wrReady(asmReady),
        .rdData(qInstr),
        .rdValid(qValid),
        .rdReady(qReady)
    );

    execUnit exec (
        .clk(clk),
        .arstN(arstN),
        .instr(qInstr),
        .instrValid(qValid),
        .instrReady(qReady),
        .result(result),
        .resultValid(resultValid),
        .resultReady(resultReady)
    );

endmodule

//--- tests/clockGen.sv
module clockGen (
    output logic clk,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for five rising edges
    initial begin
        arstN = 1'b0;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

//--- tests/z8CoreTb.sv
module z8CoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int Seed = 48185;
    localparam int NumDirected = 9;
    localparam int NumRandom = 300;
    localparam int TotalInstr = NumDirected + NumRandom;
    localparam int WaitLimit = 300;
    localparam int RunLimit = 20000;

    typedef struct packed {
        z8Pkg::resultT res;
        logic          hasValue;
    } expT;

    logic          clk;
    logic          arstN;
    z8Pkg::byteT   inByte;
    logic          inValid;
    logic          inReady;
    z8Pkg::resultT result;
    logic          resultValid;
    logic          resultReady;

    z8Pkg::byteT  mReg [16];
    z8Pkg::flagsT mFlags;
    expT          expQ [$];
    int           valueErrs = 0;
    int           flagErrs = 0;
    int           destErrs = 0;
    int           otherErrs = 0;
    int           received = 0;
    logic         timedOut = 1'b0;
    logic         stopReady = 1'b0;

    // add r3,r4 / ld r5,#80 / scf / rlc r5 / tm r5,#01 / clr r5 / ccf / cp r5,r6 / nop
    z8Pkg::byteT directedBytes [16] = '{8'h02, 8'h34, 8'h5C, 8'h80, 8'hDF, 8'h10, 8'hE5,
                                        8'h76, 8'hE5, 8'h01, 8'hB0, 8'hE5, 8'hEF, 8'hA2,
                                        8'h56, 8'hFF};
    logic [3:0] singleCodes [10] = '{4'h0, 4'h1, 4'h2, 4'h6, 4'h9, 4'hB, 4'hC, 4'hD,
                                     4'hE, 4'hF};

    clockGen clkGen (
        .clk(clk),
        .arstN(arstN)
    );

    z8Core #(
        .QueueDepth(z8Pkg::DefaultQueueDepth)
    ) uut (
        .clk(clk),
        .arstN(arstN),
        .inByte(inByte),
        .inValid(inValid),
        .inReady(inReady),
        .result(result),
        .resultValid(resultValid),
        .resultReady(resultReady)
    );

    function automatic int byteLen(input z8Pkg::byteT opc);
        if (opc[3:0] == 4'hF)
            return 1;
        if (opc[3:0] inside {4'h4, 4'h5, 4'h6, 4'h7, 4'hD})
            return 3;
        return 2;
    endfunction

    task automatic checkValue(input z8Pkg::byteT got, input z8Pkg::byteT exp, input string what);
        if (got !== exp) begin
            valueErrs++;
            $display("CHECK FAILED at %0t: %s value %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic checkFlags(input z8Pkg::flagsT got, input z8Pkg::flagsT exp,
                              input string what);
        if (got !== exp) begin
            flagErrs++;
            $display("CHECK FAILED at %0t: %s flags CZSV %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkDest(input z8Pkg::regIdxT gotDst, input z8Pkg::regIdxT expDst,
                             input logic gotWe, input logic expWe, input logic dstUsed,
                             input string what);
        if (gotWe !== expWe || (dstUsed && gotDst !== expDst)) begin
            destErrs++;
            $display("CHECK FAILED at %0t: %s dest r%0d we %b, expected r%0d we %b",
                     $time, what, gotDst, gotWe, expDst, expWe);
        end
    endtask

    // Reference model, one instruction at a time in input order
    task automatic modelStep(input z8Pkg::byteT opc, input z8Pkg::byteT b2,
                             input z8Pkg::byteT b3);
        logic [3:0]    hi;
        logic [3:0]    lo;
        z8Pkg::regIdxT d;
        z8Pkg::byteT   a;
        z8Pkg::byteT   b;
        z8Pkg::byteT   r;
        z8Pkg::flagsT  f;
        logic          we;
        logic          known;
        logic          setZs;
        logic          cin;
        int            us;
        int            ss;
        expT           e;
        hi = opc[7:4];
        lo = opc[3:0];
        f = mFlags;
        d = '0;
        r = '0;
        we = 1'b0;
        known = 1'b0;
        setZs = 1'b1;
        if (lo == 4'h2 || (lo == 4'h6 && b2[7:4] == 4'hE)) begin
            d = (lo == 4'h2) ? b2[7:4] : b2[3:0];
            b = (lo == 4'h2) ? mReg[b2[3:0]] : b3;
            a = mReg[d];
            cin = (hi == 4'h1 || hi == 4'h3) ? f.c : 1'b0;
            known = 1'b1;
            we = 1'b1;
            case (hi)
                4'h0, 4'h1: begin
                    us = int'(a) + int'(b) + int'(cin);
                    ss = int'($signed(a)) + int'($signed(b)) + int'(cin);
                    r = us[7:0];
                    f.c = (us > 255);
                    f.v = (ss > 127 || ss < -128);
                end
                4'h2, 4'h3, 4'hA: begin
                    us = int'(a) - int'(b) - int'(cin);
                    ss = int'($signed(a)) - int'($signed(b)) - int'(cin);
                    r = us[7:0];
                    f.c = (us < 0);
                    f.v = (ss > 127 || ss < -128);
                    we = (hi != 4'hA);
                end
                4'h4: r = a | b;
                4'h5: r = a & b;
                4'h6: r = ~a & b;
                4'h7: r = a & b;
                4'hB: r = a ^ b;
                default: known = 1'b0;
            endcase
            if (hi inside {4'h4, 4'h5, 4'h6, 4'h7, 4'hB})
                f.v = 1'b0;
            if (hi == 4'h6 || hi == 4'h7)
                we = 1'b0;
        end else if (lo == 4'h0 && b2[7:4] == 4'hE) begin
            d = b2[3:0];
            a = mReg[d];
            known = 1'b1;
            we = 1'b1;
            case (hi)
                4'h0: begin
                    r = a - 8'd1;
                    f.v = (int'($signed(a)) - 1 < -128);
                end
                4'h2: begin
                    r = a + 8'd1;
                    f.v = (int'($signed(a)) + 1 > 127);
                end
                4'h1: begin
                    r = {a[6:0], f.c};
                    f.c = a[7];
                end
                4'h9: begin
                    r = {a[6:0], a[7]};
                    f.c = a[7];
                end
                4'hC: begin
                    r = {f.c, a[7:1]};
                    f.c = a[0];
                end
                4'hE: begin
                    r = {a[0], a[7:1]};
                    f.c = a[0];
                end
                4'hD: begin
                    r = {a[7], a[7:1]};
                    f.c = a[0];
                end
                4'h6: r = ~a;
                4'hF: r = {a[3:0], a[7:4]};
                4'hB: begin
                    r = 8'h00;
                    setZs = 1'b0;
                end
                default: known = 1'b0;
            endcase
            // Sign change through the rotate or shift
            if (hi inside {4'h1, 4'h9, 4'hC, 4'hD, 4'hE})
                f.v = (r[7] != a[7]);
            if (hi == 4'h6 || hi == 4'hF)
                f.v = 1'b0;
        end else if (lo == 4'hC) begin
            d = hi;
            r = b2;
            we = 1'b1;
            known = 1'b1;
            setZs = 1'b0;
        end else if (opc == 8'hCF) begin
            f.c = 1'b0;
        end else if (opc == 8'hDF) begin
            f.c = 1'b1;
        end else if (opc == 8'hEF) begin
            f.c = ~f.c;
        end
        if (!known) begin
            we = 1'b0;
            d = '0;
        end else if (setZs) begin
            f.z = (r == 8'h00);
            f.s = r[7];
        end
        if (we)
            mReg[d] = r;
        mFlags = f;
        e.res.writeEn = we;
        e.res.dst = d;
        e.res.value = r;
        e.res.flags = f;
        e.hasValue = known;
        expQ.push_back(e);
    endtask

    task automatic sendByte(input z8Pkg::byteT b);
        int waitCnt;
        if (timedOut)
            return;
        if ($urandom_range(0, 99) < 30) begin
            inValid <= 1'b0;
            repeat ($urandom_range(1, 3)) @(posedge clk);
        end
        inByte <= b;
        inValid <= 1'b1;
        waitCnt = 0;
        do begin
            @(posedge clk);
            waitCnt++;
        end while (!inReady && waitCnt < WaitLimit);
        if (!inReady) begin
            otherErrs++;
            timedOut = 1'b1;
            $display("Timeout at %0t: input byte %02h not accepted in %0d cycles",
                     $time, b, WaitLimit);
        end
    endtask

    task automatic sendInstr(input z8Pkg::byteT opc, input z8Pkg::byteT b2,
                             input z8Pkg::byteT b3);
        int len;
        len = byteLen(opc);
        modelStep(opc, b2, b3);
        sendByte(opc);
        if (len > 1)
            sendByte(b2);
        if (len > 2)
            sendByte(b3);
    endtask

    task automatic driveInput();
        int idx;
        int kind;
        z8Pkg::byteT opc;
        z8Pkg::byteT b2;
        z8Pkg::byteT b3;
        logic [3:0] code;
        idx = 0;
        while (idx < 16) begin
            opc = directedBytes[idx];
            b2 = (byteLen(opc) > 1) ? directedBytes[idx + 1] : 8'h00;
            b3 = (byteLen(opc) > 2) ? directedBytes[idx + 2] : 8'h00;
            sendInstr(opc, b2, b3);
            idx += byteLen(opc);
        end
        for (int i = 0; i < NumRandom; i++) begin
            kind = $urandom_range(0, 5);
            b2 = 8'($urandom);
            b3 = 8'($urandom);
            code = 4'($urandom_range(0, 9));
            case (kind)
                0, 5: opc = {4'($urandom), 4'hC};
                1: opc = {2'b11, 2'($urandom), 4'hF};
                2: opc = {(code >= 4'd8) ? code + 4'd2 : code, 4'h2};
                3: begin
                    opc = {(code >= 4'd8) ? code + 4'd2 : code, 4'h6};
                    b2 = {4'hE, b2[3:0]};
                end
                default: begin
                    opc = {singleCodes[code], 4'h0};
                    b2 = {4'hE, b2[3:0]};
                end
            endcase
            sendInstr(opc, b2, b3);
        end
        inValid <= 1'b0;
    endtask

    // Random back-pressure with occasional long stalls
    task automatic driveReady();
        int stall;
        int cycles;
        stall = 0;
        cycles = 0;
        while (!stopReady && cycles < RunLimit) begin
            @(posedge clk);
            cycles++;
            if (stall > 0) begin
                resultReady <= 1'b0;
                stall--;
            end else if ($urandom_range(0, 99) < 3) begin
                stall = $urandom_range(20, 40);
                resultReady <= 1'b0;
            end else begin
                resultReady <= ($urandom_range(0, 99) >= 30);
            end
        end
        if (!stopReady) begin
            otherErrs++;
            $display("Run limit of %0d cycles reached before all results arrived", RunLimit);
        end
        resultReady <= 1'b1;
    endtask

    task automatic collectResults();
        int idle;
        expT e;
        z8Pkg::resultT got;
        string what;
        while (received < TotalInstr && !timedOut) begin
            idle = 0;
            do begin
                @(posedge clk);
                idle++;
            end while (!(resultValid && resultReady) && idle < WaitLimit);
            if (!(resultValid && resultReady)) begin
                otherErrs++;
                timedOut = 1'b1;
                $display("Timeout at %0t: no result in %0d cycles, %0d of %0d received",
                         $time, WaitLimit, received, TotalInstr);
            end else if (expQ.size() == 0) begin
                otherErrs++;
                received++;
                $display("Result at %0t arrived with no instruction outstanding", $time);
            end else begin
                e = expQ.pop_front();
                got = result;
                what = $sformatf("result %0d", received);
                checkDest(got.dst, e.res.dst, got.writeEn, e.res.writeEn, e.hasValue, what);
                if (e.hasValue)
                    checkValue(got.value, e.res.value, what);
                checkFlags(got.flags, e.res.flags, what);
                received++;
            end
        end
        stopReady = 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            if (resultValid) begin
                otherErrs++;
                $display("Extra result seen at %0t after all results arrived", $time);
                break;
            end
        end
    endtask

    task automatic waitReset();
        int cycles;
        cycles = 0;
        while (!arstN && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (!arstN) begin
            otherErrs++;
            timedOut = 1'b1;
            $display("Reset never released within 20 cycles");
        end
        @(posedge clk);
    endtask

    // No input yet, so no result may appear
    task automatic checkIdle();
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (resultValid !== 1'b0) begin
                otherErrs++;
                $display("resultValid high at %0t before any input", $time);
            end
        end
    endtask

    task automatic finishRun();
        $display("Errors: value %0d, flags %0d, dest %0d, other %0d, results %0d of %0d",
                 valueErrs, flagErrs, destErrs, otherErrs, received, TotalInstr);
        if (valueErrs + flagErrs + destErrs + otherErrs == 0 && received == TotalInstr)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    endtask

    initial begin
        inByte = '0;
        inValid = 1'b0;
        resultReady = 1'b0;
        void'($urandom(Seed));
        for (int i = 0; i < 16; i++)
            mReg[i] = '0;
        mFlags = '0;
        waitReset();
        if (!timedOut) begin
            checkIdle();
            fork
                driveInput();
                collectResults();
                driveReady();
            join
        end
        finishRun();
    end

endmodule

//--- vlog.f
rtl/z8Pkg.sv
rtl/z8Alu.sv
rtl/instrAssembler.sv
rtl/instrQueue.sv
rtl/execUnit.sv
rtl/z8Core.sv
tests/clockGen.sv
tests/z8CoreTb.sv
